// ==== Makefile ====
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build tb_exu with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --timescale 1ns/1ps --top-module tb_exu -f src.f -o Vtb_exu
	@out=$$(./obj_dir/Vtb_exu); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

// ==== src.f ====
+incdir+src
+incdir+testbench
src/exu_pkg.sv
src/exu_wb_if.sv
src/exu_wb_stage.sv
src/exu_alu.sv
src/exu_bru.sv
src/exu_csr_unit.sv
src/exu.sv
testbench/tb_exu.sv

// ==== src/exu.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"

module exu (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   int_jump_i,
    input  logic [`EXU_ADDR_W-1:0] int_addr_i,

    // alu lane 0
    input  logic                   req_alu0_i,
    input  logic [`EXU_DATA_W-1:0] alu0_op1_i,
    input  logic [`EXU_DATA_W-1:0] alu0_op2_i,
    input  exu_pkg::alu_op_e       alu0_op_i,
    input  logic [`EXU_REG_W-1:0]  alu0_rd_i,
    input  logic [`EXU_CID_W-1:0]  alu0_commit_id_i,
    input  logic                   alu0_reg_we_i,
    input  logic                   alu0_wb_ready_i,
    output logic [`EXU_DATA_W-1:0] alu0_reg_wdata_o,
    output logic                   alu0_reg_we_o,
    output logic [`EXU_REG_W-1:0]  alu0_reg_waddr_o,
    output logic [`EXU_CID_W-1:0]  alu0_commit_id_o,

    // alu lane 1
    input  logic                   req_alu1_i,
    input  logic [`EXU_DATA_W-1:0] alu1_op1_i,
    input  logic [`EXU_DATA_W-1:0] alu1_op2_i,
    input  exu_pkg::alu_op_e       alu1_op_i,
    input  logic [`EXU_REG_W-1:0]  alu1_rd_i,
    input  logic [`EXU_CID_W-1:0]  alu1_commit_id_i,
    input  logic                   alu1_reg_we_i,
    input  logic                   alu1_wb_ready_i,
    output logic [`EXU_DATA_W-1:0] alu1_reg_wdata_o,
    output logic                   alu1_reg_we_o,
    output logic [`EXU_REG_W-1:0]  alu1_reg_waddr_o,
    output logic [`EXU_CID_W-1:0]  alu1_commit_id_o,

    // branch unit
    input  logic                   req_bjp_i,
    input  logic [`EXU_DATA_W-1:0] bjp_op1_i,
    input  logic [`EXU_DATA_W-1:0] bjp_op2_i,
    input  logic [`EXU_ADDR_W-1:0] bjp_jump_op1_i,
    input  logic [`EXU_ADDR_W-1:0] bjp_jump_op2_i,
    input  exu_pkg::bjp_op_e       bjp_op_i,

    // csr lane 0
    input  logic                   req_csr0_i,
    input  logic [`EXU_DATA_W-1:0] csr0_op1_i,
    input  logic [`EXU_CSR_W-1:0]  csr0_addr_i,
    input  exu_pkg::csr_op_e       csr0_op_i,
    input  logic [`EXU_DATA_W-1:0] csr0_rdata_i,
    input  logic [`EXU_REG_W-1:0]  csr0_rd_i,
    input  logic [`EXU_CID_W-1:0]  csr0_commit_id_i,
    input  logic                   csr0_reg_we_i,
    input  logic                   csr0_wb_ready_i,
    output logic [`EXU_DATA_W-1:0] csr0_reg_wdata_o,
    output logic                   csr0_reg_we_o,
    output logic [`EXU_REG_W-1:0]  csr0_reg_waddr_o,
    output logic [`EXU_CID_W-1:0]  csr0_commit_id_o,
    output logic [`EXU_DATA_W-1:0] csr0_wdata_o,
    output logic                   csr0_we_o,
    output logic [`EXU_CSR_W-1:0]  csr0_waddr_o,

    // csr lane 1
    input  logic                   req_csr1_i,
    input  logic [`EXU_DATA_W-1:0] csr1_op1_i,
    input  logic [`EXU_CSR_W-1:0]  csr1_addr_i,
    input  exu_pkg::csr_op_e       csr1_op_i,
    input  logic [`EXU_DATA_W-1:0] csr1_rdata_i,
    input  logic [`EXU_REG_W-1:0]  csr1_rd_i,
    input  logic [`EXU_CID_W-1:0]  csr1_commit_id_i,
    input  logic                   csr1_reg_we_i,
    input  logic                   csr1_wb_ready_i,
    output logic [`EXU_DATA_W-1:0] csr1_reg_wdata_o,
    output logic                   csr1_reg_we_o,
    output logic [`EXU_REG_W-1:0]  csr1_reg_waddr_o,
    output logic [`EXU_CID_W-1:0]  csr1_commit_id_o,
    output logic [`EXU_DATA_W-1:0] csr1_wdata_o,
    output logic                   csr1_we_o,
    output logic [`EXU_CSR_W-1:0]  csr1_waddr_o,

    output logic                   stall_flag_o,
    output logic                   jump_flag_o,
    output logic [`EXU_ADDR_W-1:0] jump_addr_o,
    output logic                   misaligned_fetch_o
);

    logic                   alu0_stall;
    logic                   alu1_stall;
    logic                   csr0_stall;
    logic                   csr1_stall;
    logic                   csr_grant1;
    logic                   csr_deny;
    logic                   bru_jump;
    logic [`EXU_ADDR_W-1:0] bru_target;

    exu_wb_if alu0_wb ();
    exu_wb_if alu1_wb ();
    exu_wb_if csr0_wb ();
    exu_wb_if csr1_wb ();

    // ==================================================================
    // alu lanes
    // ==================================================================
    exu_alu u_alu0 (
        .clk (clk), .rst_n_i (rst_n_i), .stall_i (stall_i), .flush_i (flush_i),
        .req_i       (req_alu0_i),
        .op1_i       (alu0_op1_i),
        .op2_i       (alu0_op2_i),
        .op_i        (alu0_op_i),
        .rd_i        (alu0_rd_i),
        .commit_id_i (alu0_commit_id_i),
        .reg_we_i    (alu0_reg_we_i),
        .stall_o     (alu0_stall),
        .wb          (alu0_wb)
    );

    exu_alu u_alu1 (
        .clk (clk), .rst_n_i (rst_n_i), .stall_i (stall_i), .flush_i (flush_i),
        .req_i       (req_alu1_i),
        .op1_i       (alu1_op1_i),
        .op2_i       (alu1_op2_i),
        .op_i        (alu1_op_i),
        .rd_i        (alu1_rd_i),
        .commit_id_i (alu1_commit_id_i),
        .reg_we_i    (alu1_reg_we_i),
        .stall_o     (alu1_stall),
        .wb          (alu1_wb)
    );

    // ==================================================================
    // branch unit and jump select
    // ==================================================================
    // only an accepted branch may redirect fetch
    exu_bru u_bru (
        .req_i        (req_bjp_i & ~stall_i & ~flush_i),
        .op1_i        (bjp_op1_i),
        .op2_i        (bjp_op2_i),
        .jump_op1_i   (bjp_jump_op1_i),
        .jump_op2_i   (bjp_jump_op2_i),
        .op_i         (bjp_op_i),
        .jump_o       (bru_jump),
        .target_o     (bru_target),
        .misaligned_o (misaligned_fetch_o)
    );

    assign jump_flag_o = bru_jump | int_jump_i;
    assign jump_addr_o = int_jump_i ? int_addr_i : bru_target;

    // ==================================================================
    // csr arbiter with fixed priority for lane 0
    // ==================================================================
    assign csr_deny   = req_csr0_i & req_csr1_i;
    assign csr_grant1 = req_csr1_i & ~req_csr0_i;

    exu_csr_unit u_csr0 (
        .clk (clk), .rst_n_i (rst_n_i), .stall_i (stall_i), .flush_i (flush_i),
        .req_i (req_csr0_i), .op1_i (csr0_op1_i), .addr_i (csr0_addr_i),
        .op_i (csr0_op_i), .rdata_i (csr0_rdata_i), .rd_i (csr0_rd_i),
        .commit_id_i (csr0_commit_id_i), .reg_we_i (csr0_reg_we_i),
        .stall_o (csr0_stall), .wb (csr0_wb),
        .csr_wdata_o (csr0_wdata_o), .csr_we_o (csr0_we_o), .csr_waddr_o (csr0_waddr_o)
    );

    exu_csr_unit u_csr1 (
        .clk (clk), .rst_n_i (rst_n_i), .stall_i (stall_i), .flush_i (flush_i),
        .req_i (csr_grant1), .op1_i (csr1_op1_i), .addr_i (csr1_addr_i),
        .op_i (csr1_op_i), .rdata_i (csr1_rdata_i), .rd_i (csr1_rd_i),
        .commit_id_i (csr1_commit_id_i), .reg_we_i (csr1_reg_we_i),
        .stall_o (csr1_stall), .wb (csr1_wb),
        .csr_wdata_o (csr1_wdata_o), .csr_we_o (csr1_we_o), .csr_waddr_o (csr1_waddr_o)
    );

    // writeback ports out to the top level
    assign alu0_wb.ready    = alu0_wb_ready_i;
    assign alu0_reg_wdata_o = alu0_wb.wdata;
    assign alu0_reg_we_o    = alu0_wb.we;
    assign alu0_reg_waddr_o = alu0_wb.waddr;
    assign alu0_commit_id_o = alu0_wb.commit_id;

    assign alu1_wb.ready    = alu1_wb_ready_i;
    assign alu1_reg_wdata_o = alu1_wb.wdata;
    assign alu1_reg_we_o    = alu1_wb.we;
    assign alu1_reg_waddr_o = alu1_wb.waddr;
    assign alu1_commit_id_o = alu1_wb.commit_id;

    assign csr0_wb.ready    = csr0_wb_ready_i;
    assign csr0_reg_wdata_o = csr0_wb.wdata;
    assign csr0_reg_we_o    = csr0_wb.we;
    assign csr0_reg_waddr_o = csr0_wb.waddr;
    assign csr0_commit_id_o = csr0_wb.commit_id;

    assign csr1_wb.ready    = csr1_wb_ready_i;
    assign csr1_reg_wdata_o = csr1_wb.wdata;
    assign csr1_reg_we_o    = csr1_wb.we;
    assign csr1_reg_waddr_o = csr1_wb.waddr;
    assign csr1_commit_id_o = csr1_wb.commit_id;

    // a denied csr1 request holds the pipe like a full lane does
    assign stall_flag_o = alu0_stall | alu1_stall | csr0_stall | csr1_stall | csr_deny;

endmodule

// ==== src/exu_alu.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_alu (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   req_i,
    input  logic [`EXU_DATA_W-1:0] op1_i,
    input  logic [`EXU_DATA_W-1:0] op2_i,
    input  exu_pkg::alu_op_e       op_i,
    input  logic [`EXU_REG_W-1:0]  rd_i,
    input  logic [`EXU_CID_W-1:0]  commit_id_i,
    input  logic                   reg_we_i,
    output logic                   stall_o,
    exu_wb_if.src                  wb
);

    import exu_pkg::*;

    logic [`EXU_DATA_W-1:0] result;
    logic [4:0]             shamt;
    logic                   take;
    logic                   full;
    logic                   drain;
    wb_data_t               in_d;
    wb_data_t               out_d;

    assign shamt = op2_i[4:0];

    always_comb begin
        case (op_i)
            ADD:     result = op1_i + op2_i;
            SUB:     result = op1_i - op2_i;
            SLL:     result = op1_i << shamt;
            SLT:     result = {{(`EXU_DATA_W-1){1'b0}}, $signed(op1_i) < $signed(op2_i)};
            SLTU:    result = {{(`EXU_DATA_W-1){1'b0}}, op1_i < op2_i};
            XOR:     result = op1_i ^ op2_i;
            SRL:     result = op1_i >> shamt;
            SRA:     result = $signed(op1_i) >>> shamt;
            OR:      result = op1_i | op2_i;
            AND:     result = op1_i & op2_i;
            LUI:     result = op2_i;
            default: result = '0;
        endcase
    end

    // taken when the stage is empty or drains on this edge
    assign take    = req_i & ~stall_i & ~flush_i & (~full | drain);
    assign stall_o = req_i & ~stall_i & ~flush_i & full & ~drain;

    assign in_d = '{wdata: result, waddr: rd_i, commit_id: commit_id_i, reg_we: reg_we_i};

    // no register write means nothing to hold
    exu_wb_stage #(
        .payload_t (wb_data_t)
    ) u_stage (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .load_i  (take & reg_we_i),
        .data_i  (in_d),
        .ready_i (wb.ready),
        .full_o  (full),
        .data_o  (out_d),
        .drain_o (drain)
    );

    assign wb.wdata     = out_d.wdata;
    assign wb.we        = full & out_d.reg_we;
    assign wb.waddr     = out_d.waddr;
    assign wb.commit_id = out_d.commit_id;

endmodule

// ==== src/exu_bru.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_bru (
    input  logic                   req_i,
    input  logic [`EXU_DATA_W-1:0] op1_i,
    input  logic [`EXU_DATA_W-1:0] op2_i,
    input  logic [`EXU_ADDR_W-1:0] jump_op1_i,
    input  logic [`EXU_ADDR_W-1:0] jump_op2_i,
    input  exu_pkg::bjp_op_e       op_i,
    output logic                   jump_o,
    output logic [`EXU_ADDR_W-1:0] target_o,
    output logic                   misaligned_o
);

    import exu_pkg::*;

    logic                   eq;
    logic                   lt_s;
    logic                   lt_u;
    logic                   taken;
    logic [`EXU_ADDR_W-1:0] sum;

    assign eq   = (op1_i == op2_i);
    assign lt_s = $signed(op1_i) < $signed(op2_i);
    assign lt_u = op1_i < op2_i;

    always_comb begin
        case (op_i)
            JAL,
            JALR:    taken = 1'b1;
            BEQ:     taken = eq;
            BNE:     taken = ~eq;
            BLT:     taken = lt_s;
            BGE:     taken = ~lt_s;
            BLTU:    taken = lt_u;
            BGEU:    taken = ~lt_u;
            default: taken = 1'b0;
        endcase
    end

    assign sum = jump_op1_i + jump_op2_i;

    // jalr drops bit 0 of the computed address
    assign target_o = (op_i == JALR) ? {sum[`EXU_ADDR_W-1:1], 1'b0} : sum;

    assign jump_o = req_i & taken;

    // without the C extension targets must be word aligned
    assign misaligned_o = jump_o & target_o[1];

endmodule

// ==== src/exu_csr_unit.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"

module exu_csr_unit (
    input  logic                   clk,
    input  logic                   rst_n_i,
    input  logic                   stall_i,
    input  logic                   flush_i,
    input  logic                   req_i,
    input  logic [`EXU_DATA_W-1:0] op1_i,
    input  logic [`EXU_CSR_W-1:0]  addr_i,
    input  exu_pkg::csr_op_e       op_i,
    input  logic [`EXU_DATA_W-1:0] rdata_i,
    input  logic [`EXU_REG_W-1:0]  rd_i,
    input  logic [`EXU_CID_W-1:0]  commit_id_i,
    input  logic                   reg_we_i,
    output logic                   stall_o,
    exu_wb_if.src                  wb,
    output logic [`EXU_DATA_W-1:0] csr_wdata_o,
    output logic                   csr_we_o,
    output logic [`EXU_CSR_W-1:0]  csr_waddr_o
);

    import exu_pkg::*;

    logic [`EXU_DATA_W-1:0] new_val;
    logic                   new_we;
    logic                   take;
    logic                   full;
    logic                   drain;
    csr_wb_t                in_d;
    csr_wb_t                out_d;

    always_comb begin
        case (op_i)
            CSRRW:   new_val = op1_i;
            CSRRS:   new_val = rdata_i | op1_i;
            CSRRC:   new_val = rdata_i & ~op1_i;
            default: new_val = rdata_i;
        endcase
    end

    // set/clear with a zero mask leaves the csr untouched
    assign new_we = ~(((op_i == CSRRS) || (op_i == CSRRC)) && (op1_i == '0));

    assign take    = req_i & ~stall_i & ~flush_i & (~full | drain);
    assign stall_o = req_i & ~stall_i & ~flush_i & full & ~drain;

    assign in_d.wb        = '{wdata: rdata_i, waddr: rd_i, commit_id: commit_id_i,
                              reg_we: reg_we_i};
    assign in_d.csr_wdata = new_val;
    assign in_d.csr_waddr = addr_i;
    assign in_d.csr_we    = new_we;

    // loaded even without an rd write since the csr write still has to go out
    exu_wb_stage #(
        .payload_t (csr_wb_t)
    ) u_stage (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .load_i  (take),
        .data_i  (in_d),
        .ready_i (wb.ready),
        .full_o  (full),
        .data_o  (out_d),
        .drain_o (drain)
    );

    assign wb.wdata     = out_d.wb.wdata;
    assign wb.we        = full & out_d.wb.reg_we;
    assign wb.waddr     = out_d.wb.waddr;
    assign wb.commit_id = out_d.wb.commit_id;

    assign csr_wdata_o = out_d.csr_wdata;
    assign csr_waddr_o = out_d.csr_waddr;
    assign csr_we_o    = drain & out_d.csr_we;

endmodule

// ==== src/exu_params.svh ====
`ifndef EXU_PARAMS_SVH
`define EXU_PARAMS_SVH

// datapath widths of the execute stage
`define EXU_DATA_W 32
`define EXU_REG_W 5
`define EXU_CID_W 4
`define EXU_CSR_W 12
`define EXU_ADDR_W 32

`endif

// ==== src/exu_pkg.sv ====
`include "exu_params.svh"

package exu_pkg;

    // ==================================================================
    // operation encodings
    // ==================================================================
    typedef enum logic [3:0] {
        ADD, SUB, SLL, SLT, SLTU, XOR, SRL, SRA, OR, AND, LUI
    } alu_op_e;

    typedef enum logic [2:0] {
        JAL, JALR, BEQ, BNE, BLT, BGE, BLTU, BGEU
    } bjp_op_e;

    // matches funct3 of the zicsr register forms
    typedef enum logic [1:0] {
        CSRRW = 2'd1,
        CSRRS = 2'd2,
        CSRRC = 2'd3
    } csr_op_e;

    // ==================================================================
    // writeback payloads
    // ==================================================================
    typedef struct packed {
        logic [`EXU_DATA_W-1:0] wdata;
        logic [`EXU_REG_W-1:0]  waddr;
        logic [`EXU_CID_W-1:0]  commit_id;
        logic                   reg_we;
    } wb_data_t;

    typedef struct packed {
        wb_data_t               wb;
        logic [`EXU_DATA_W-1:0] csr_wdata;
        logic [`EXU_CSR_W-1:0]  csr_waddr;
        logic                   csr_we;
    } csr_wb_t;

endpackage

// ==== src/exu_wb_if.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"

// one register writeback port toward the writeback unit
interface exu_wb_if;

    logic [`EXU_DATA_W-1:0] wdata;
    logic                   we;
    logic [`EXU_REG_W-1:0]  waddr;
    logic [`EXU_CID_W-1:0]  commit_id;
    logic                   ready;

    // execution unit side
    modport src (output wdata, we, waddr, commit_id, input ready);

    // top level side
    modport dst (input wdata, we, waddr, commit_id, output ready);

endinterface

// ==== src/exu_wb_stage.sv ====
`timescale 1ns/1ps

module exu_wb_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n_i,
    input  logic     load_i,
    input  payload_t data_i,
    input  logic     ready_i,
    output logic     full_o,
    output payload_t data_o,
    output logic     drain_o
);

    logic     full_q;
    payload_t data_q;

    // entry leaves on this edge, so a new load may replace it
    assign drain_o = full_q & ready_i;

    always_ff @(posedge clk or negedge rst_n_i) begin
        if (!rst_n_i) begin
            full_q <= 1'b0;
        end else if (load_i) begin
            full_q <= 1'b1;
        end else if (drain_o) begin
            full_q <= 1'b0;
        end
    end

    // payload only changes on a load and holds under back-pressure
    always_ff @(posedge clk) begin
        if (load_i) begin
            data_q <= data_i;
        end
    end

    assign full_o = full_q;
    assign data_o = data_q;

endmodule

// ==== testbench/tb_exu_model.svh ====
`ifndef TB_EXU_MODEL_SVH
`define TB_EXU_MODEL_SVH

// ======================================================================
// reference model state
// ======================================================================
logic     m_alu_full [2];
wb_data_t m_alu_q    [2];
logic     m_csr_full [2];
csr_wb_t  m_csr_q    [2];

// csr file behind the rdata inputs
word_t csr_file [0:(1 << `EXU_CSR_W) - 1];

task automatic init_model();
    logic [`EXU_CSR_W-1:0] a;
    m_alu_full[0] = 1'b0;
    m_alu_full[1] = 1'b0;
    m_csr_full[0] = 1'b0;
    m_csr_full[1] = 1'b0;
    m_alu_q[0]    = '0;
    m_alu_q[1]    = '0;
    m_csr_q[0]    = '0;
    m_csr_q[1]    = '0;
    a = '0;
    do begin
        csr_file[a] = {a, ~a, 8'h5a};
        a++;
    end while (a != '0);
endtask

// rv32i integer ops
function automatic word_t alu_ref(alu_op_e op, word_t a, word_t b);
    logic [4:0] sh;
    word_t      fill;
    logic       lt_s;
    sh   = b[4:0];
    fill = a[`EXU_DATA_W-1] ? ~({`EXU_DATA_W{1'b1}} >> sh) : '0;
    lt_s = (a[`EXU_DATA_W-1] != b[`EXU_DATA_W-1]) ? a[`EXU_DATA_W-1] : (a < b);
    case (op)
        ADD:     return a + b;
        SUB:     return a + ~b + word_t'(1);
        SLL:     return a << sh;
        SLT:     return word_t'(lt_s);
        SLTU:    return word_t'(a < b);
        XOR:     return a ^ b;
        SRL:     return a >> sh;
        SRA:     return (a >> sh) | fill;
        OR:      return a | b;
        AND:     return a & b;
        LUI:     return b;
        default: return '0;
    endcase
endfunction

function automatic logic branch_taken(bjp_op_e op, word_t a, word_t b);
    logic lt_s;
    lt_s = (a[`EXU_DATA_W-1] != b[`EXU_DATA_W-1]) ? a[`EXU_DATA_W-1] : (a < b);
    case (op)
        JAL, JALR: return 1'b1;
        BEQ:       return a == b;
        BNE:       return a != b;
        BLT:       return lt_s;
        BGE:       return !lt_s;
        BLTU:      return a < b;
        BGEU:      return a >= b;
        default:   return 1'b0;
    endcase
endfunction

// lane 0 wins when both csr lanes ask
function automatic logic csr_granted(bit n);
    return n ? (csr_req[1] && !csr_req[0]) : csr_req[0];
endfunction

function automatic logic lane_stall(bit n);
    logic open;
    open = !stall_i && !flush_i;
    return open && ((alu_req[n] && m_alu_full[n] && !alu_ready[n]) ||
                    (csr_granted(n) && m_csr_full[n] && !csr_ready[n]));
endfunction

// ======================================================================
// compare tasks
// ======================================================================
task automatic report_mismatch(string name, logic [127:0] exp, logic [127:0] act);
    $display("Fail at %0t ns: %s expected %0h, got %0h", $time, name, exp, act);
    stop_run();
endtask

task automatic check_wb(string name, wb_data_t exp, wb_data_t act);
    // payload only counts while we is up
    if (act.reg_we !== exp.reg_we || (exp.reg_we && act !== exp)) begin
        report_mismatch(name, 128'(exp), 128'(act));
    end
endtask

task automatic check_csr(string name, logic valid, csr_wb_t exp, csr_wb_t act);
    logic bad;
    if (valid) begin
        bad = (act !== exp);
    end else begin
        bad = (act.wb.reg_we !== exp.wb.reg_we) || (act.csr_we !== exp.csr_we);
    end
    if (bad) begin
        report_mismatch(name, 128'(exp), 128'(act));
    end
endtask

task automatic check_jump(logic exp_flag, addr_t exp_addr, logic exp_mis,
                          logic act_flag, addr_t act_addr, logic act_mis);
    if (act_flag !== exp_flag) begin
        report_mismatch("jump_flag_o", 128'(exp_flag), 128'(act_flag));
    end else if (exp_flag && act_addr !== exp_addr) begin
        report_mismatch("jump_addr_o", 128'(exp_addr), 128'(act_addr));
    end else if (act_mis !== exp_mis) begin
        report_mismatch("misaligned_fetch_o", 128'(exp_mis), 128'(act_mis));
    end
endtask

task automatic check_bit(string name, logic exp, logic act);
    if (act !== exp) begin
        report_mismatch(name, 128'(exp), 128'(act));
    end
endtask

`endif

// ==== testbench/tb_exu.sv ====
`timescale 1ns/1ps
`include "exu_params.svh"

module tb_exu;

    import exu_pkg::*;

    localparam int CYCLES = 2000;
    localparam int PERIOD = 40;
    localparam int REG_W  = `EXU_REG_W;
    localparam int CID_W  = `EXU_CID_W;
    localparam int CSR_W  = `EXU_CSR_W;

    typedef logic [`EXU_DATA_W-1:0] word_t;
    typedef logic [`EXU_ADDR_W-1:0] addr_t;

    logic   clk;
    logic   rst_n;
    logic   stall_i;
    logic   flush_i;
    logic   int_jump;
    addr_t  int_addr;
    integer seed;

    logic             alu_req     [2];
    word_t            alu_op1     [2];
    word_t            alu_op2     [2];
    alu_op_e          alu_op      [2];
    logic [REG_W-1:0] alu_rd      [2];
    logic [CID_W-1:0] alu_cid     [2];
    logic             alu_rwe     [2];
    logic             alu_ready   [2];
    word_t            alu_wdata   [2];
    logic             alu_we      [2];
    logic [REG_W-1:0] alu_waddr   [2];
    logic [CID_W-1:0] alu_cid_out [2];

    logic    req_bjp;
    word_t   bjp_op1;
    word_t   bjp_op2;
    addr_t   bjp_jop1;
    addr_t   bjp_jop2;
    bjp_op_e bjp_op;

    logic             csr_req       [2];
    word_t            csr_op1       [2];
    logic [CSR_W-1:0] csr_addr      [2];
    csr_op_e          csr_op        [2];
    word_t            csr_rdata     [2];
    logic [REG_W-1:0] csr_rd        [2];
    logic [CID_W-1:0] csr_cid       [2];
    logic             csr_rwe       [2];
    logic             csr_ready     [2];
    word_t            csr_reg_wdata [2];
    logic             csr_reg_we    [2];
    logic [REG_W-1:0] csr_reg_waddr [2];
    logic [CID_W-1:0] csr_cid_out   [2];
    word_t            csr_wdata     [2];
    logic             csr_we        [2];
    logic [CSR_W-1:0] csr_waddr     [2];

    logic  stall_flag;
    logic  jump_flag;
    addr_t jump_addr;
    logic  misaligned;

    exu exu_inst (
        .clk (clk), .rst_n_i (rst_n), .stall_i (stall_i), .flush_i (flush_i),
        .int_jump_i (int_jump), .int_addr_i (int_addr),
        .req_alu0_i (alu_req[0]), .alu0_op1_i (alu_op1[0]), .alu0_op2_i (alu_op2[0]),
        .alu0_op_i (alu_op[0]), .alu0_rd_i (alu_rd[0]), .alu0_commit_id_i (alu_cid[0]),
        .alu0_reg_we_i (alu_rwe[0]), .alu0_wb_ready_i (alu_ready[0]),
        .alu0_reg_wdata_o (alu_wdata[0]), .alu0_reg_we_o (alu_we[0]),
        .alu0_reg_waddr_o (alu_waddr[0]), .alu0_commit_id_o (alu_cid_out[0]),
        .req_alu1_i (alu_req[1]), .alu1_op1_i (alu_op1[1]), .alu1_op2_i (alu_op2[1]),
        .alu1_op_i (alu_op[1]), .alu1_rd_i (alu_rd[1]), .alu1_commit_id_i (alu_cid[1]),
        .alu1_reg_we_i (alu_rwe[1]), .alu1_wb_ready_i (alu_ready[1]),
        .alu1_reg_wdata_o (alu_wdata[1]), .alu1_reg_we_o (alu_we[1]),
        .alu1_reg_waddr_o (alu_waddr[1]), .alu1_commit_id_o (alu_cid_out[1]),
        .req_bjp_i (req_bjp), .bjp_op1_i (bjp_op1), .bjp_op2_i (bjp_op2),
        .bjp_jump_op1_i (bjp_jop1), .bjp_jump_op2_i (bjp_jop2), .bjp_op_i (bjp_op),
        .req_csr0_i (csr_req[0]), .csr0_op1_i (csr_op1[0]), .csr0_addr_i (csr_addr[0]),
        .csr0_op_i (csr_op[0]), .csr0_rdata_i (csr_rdata[0]), .csr0_rd_i (csr_rd[0]),
        .csr0_commit_id_i (csr_cid[0]), .csr0_reg_we_i (csr_rwe[0]),
        .csr0_wb_ready_i (csr_ready[0]),
        .csr0_reg_wdata_o (csr_reg_wdata[0]), .csr0_reg_we_o (csr_reg_we[0]),
        .csr0_reg_waddr_o (csr_reg_waddr[0]), .csr0_commit_id_o (csr_cid_out[0]),
        .csr0_wdata_o (csr_wdata[0]), .csr0_we_o (csr_we[0]), .csr0_waddr_o (csr_waddr[0]),
        .req_csr1_i (csr_req[1]), .csr1_op1_i (csr_op1[1]), .csr1_addr_i (csr_addr[1]),
        .csr1_op_i (csr_op[1]), .csr1_rdata_i (csr_rdata[1]), .csr1_rd_i (csr_rd[1]),
        .csr1_commit_id_i (csr_cid[1]), .csr1_reg_we_i (csr_rwe[1]),
        .csr1_wb_ready_i (csr_ready[1]),
        .csr1_reg_wdata_o (csr_reg_wdata[1]), .csr1_reg_we_o (csr_reg_we[1]),
        .csr1_reg_waddr_o (csr_reg_waddr[1]), .csr1_commit_id_o (csr_cid_out[1]),
        .csr1_wdata_o (csr_wdata[1]), .csr1_we_o (csr_we[1]), .csr1_waddr_o (csr_waddr[1]),
        .stall_flag_o (stall_flag), .jump_flag_o (jump_flag), .jump_addr_o (jump_addr),
        .misaligned_fetch_o (misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    task automatic stop_run();
        $display("Errors found");
        $fatal(1, "run stopped at the first error");
    endtask

    `include "tb_exu_model.svh"

    // ==================================================================
    // stimulus helpers
    // ==================================================================
    function automatic word_t rnd();
        return $random(seed);
    endfunction

    function automatic logic chance(int unsigned pct);
        return (rnd() % 100) < pct;
    endfunction

    // small signed values often, so compares hit equal and sign cases
    function automatic word_t operand();
        word_t r;
        r = rnd();
        return r[2] ? rnd() : {{(`EXU_DATA_W-4){r[7]}}, r[7:4]};
    endfunction

    task automatic zero_lane(bit n);
        alu_req[n]   = 1'b0;
        alu_op1[n]   = '0;
        alu_op2[n]   = '0;
        alu_op[n]    = ADD;
        alu_rd[n]    = '0;
        alu_cid[n]   = '0;
        alu_rwe[n]   = 1'b0;
        alu_ready[n] = 1'b0;
        csr_req[n]   = 1'b0;
        csr_op1[n]   = '0;
        csr_addr[n]  = '0;
        csr_op[n]    = CSRRW;
        csr_rdata[n] = '0;
        csr_rd[n]    = '0;
        csr_cid[n]   = '0;
        csr_rwe[n]   = 1'b0;
        csr_ready[n] = 1'b0;
    endtask

    task automatic drive_lane(bit n);
        word_t a;
        a = operand();
        alu_req[n]   = chance(60);
        alu_op1[n]   = a;
        alu_op2[n]   = chance(20) ? a : operand();
        alu_op[n]    = alu_op_e'(4'(rnd() % 11));
        alu_rd[n]    = REG_W'(rnd());
        alu_cid[n]   = CID_W'(rnd());
        alu_rwe[n]   = chance(80);
        alu_ready[n] = chance(75);
        csr_req[n]   = chance(30);
        csr_op1[n]   = chance(25) ? '0 : operand();
        csr_addr[n]  = 12'h340 + CSR_W'(rnd() % 4);
        csr_op[n]    = csr_op_e'(2'(rnd() % 3 + 1));
        csr_rdata[n] = csr_file[csr_addr[n]];
        csr_rd[n]    = REG_W'(rnd());
        csr_cid[n]   = CID_W'(rnd());
        csr_rwe[n]   = chance(85);
        csr_ready[n] = chance(75);
    endtask

    task automatic drive_inputs();
        word_t r;
        drive_lane(1'b0);
        drive_lane(1'b1);
        stall_i  = chance(8);
        flush_i  = chance(5);
        int_jump = chance(8);
        int_addr = rnd();
        req_bjp  = chance(50);
        bjp_op1  = operand();
        bjp_op2  = chance(25) ? bjp_op1 : operand();
        bjp_op   = bjp_op_e'(3'(rnd()));
        bjp_jop1 = rnd();
        r        = rnd();
        bjp_jop2 = chance(60) ? {r[`EXU_ADDR_W-1:2], 2'b00} : r;
    endtask

    // ==================================================================
    // expected outputs and model update
    // ==================================================================
    task automatic check_lane(bit n);
        wb_data_t exp_wb;
        wb_data_t act_wb;
        csr_wb_t  exp_csr;
        csr_wb_t  act_csr;
        exp_wb        = m_alu_q[n];
        exp_wb.reg_we = m_alu_full[n];
        act_wb = '{wdata: alu_wdata[n], waddr: alu_waddr[n], commit_id: alu_cid_out[n],
                   reg_we: alu_we[n]};
        check_wb($sformatf("alu%0d writeback port", n), exp_wb, act_wb);
        exp_csr           = m_csr_q[n];
        exp_csr.wb.reg_we = m_csr_full[n] && m_csr_q[n].wb.reg_we;
        exp_csr.csr_we    = m_csr_full[n] && csr_ready[n] && m_csr_q[n].csr_we;
        act_csr.wb = '{wdata: csr_reg_wdata[n], waddr: csr_reg_waddr[n],
                       commit_id: csr_cid_out[n], reg_we: csr_reg_we[n]};
        act_csr.csr_wdata = csr_wdata[n];
        act_csr.csr_waddr = csr_waddr[n];
        act_csr.csr_we    = csr_we[n];
        check_csr($sformatf("csr%0d writeback port", n), m_csr_full[n], exp_csr, act_csr);
    endtask

    task automatic check_all();
        logic  exp_stall;
        logic  bru_jump;
        addr_t target;
        check_lane(1'b0);
        check_lane(1'b1);
        exp_stall = (csr_req[0] && csr_req[1]) || lane_stall(1'b0) || lane_stall(1'b1);
        target = bjp_jop1 + bjp_jop2;
        if (bjp_op == JALR) begin
            target[0] = 1'b0;
        end
        bru_jump = req_bjp && !stall_i && !flush_i && branch_taken(bjp_op, bjp_op1, bjp_op2);
        check_jump(bru_jump || int_jump, int_jump ? int_addr : target, bru_jump && target[1],
                   jump_flag, jump_addr, misaligned);
        check_bit("stall_flag_o", exp_stall, stall_flag);
    endtask

    task automatic update_lane(bit n);
        logic  open;
        logic  drain;
        logic  take;
        word_t nv;
        open  = !stall_i && !flush_i;
        drain = m_alu_full[n] && alu_ready[n];
        take  = open && alu_req[n] && (!m_alu_full[n] || drain);
        if (take && alu_rwe[n]) begin
            m_alu_full[n] = 1'b1;
            m_alu_q[n] = '{wdata: alu_ref(alu_op[n], alu_op1[n], alu_op2[n]),
                           waddr: alu_rd[n], commit_id: alu_cid[n], reg_we: 1'b1};
        end else if (drain) begin
            m_alu_full[n] = 1'b0;
        end
        drain = m_csr_full[n] && csr_ready[n];
        take  = open && csr_granted(n) && (!m_csr_full[n] || drain);
        if (drain && m_csr_q[n].csr_we) begin
            csr_file[m_csr_q[n].csr_waddr] = m_csr_q[n].csr_wdata;
        end
        if (take) begin
            case (csr_op[n])
                CSRRS:   nv = csr_rdata[n] | csr_op1[n];
                CSRRC:   nv = csr_rdata[n] & ~csr_op1[n];
                default: nv = csr_op1[n];
            endcase
            m_csr_full[n] = 1'b1;
            m_csr_q[n].wb = '{wdata: csr_rdata[n], waddr: csr_rd[n], commit_id: csr_cid[n],
                              reg_we: csr_rwe[n]};
            m_csr_q[n].csr_wdata = nv;
            m_csr_q[n].csr_waddr = csr_addr[n];
            m_csr_q[n].csr_we    = (csr_op[n] == CSRRW) || (csr_op1[n] != '0);
        end else if (drain) begin
            m_csr_full[n] = 1'b0;
        end
    endtask

    // ==================================================================
    // main sequence
    // ==================================================================
    initial begin : stimulus
        seed     = 16;
        rst_n    = 1'b0;
        stall_i  = 1'b0;
        flush_i  = 1'b0;
        int_jump = 1'b0;
        int_addr = '0;
        req_bjp  = 1'b0;
        bjp_op1  = '0;
        bjp_op2  = '0;
        bjp_jop1 = '0;
        bjp_jop2 = '0;
        bjp_op   = JAL;
        zero_lane(1'b0);
        zero_lane(1'b1);
        init_model();
        repeat (4) @(posedge clk);
        @(negedge clk);
        // quiet outputs straight out of reset
        check_all();
        rst_n = 1'b1;
        repeat (CYCLES) begin
            @(negedge clk);
            drive_inputs();
            #(PERIOD / 4);
            check_all();
            update_lane(1'b0);
            update_lane(1'b1);
        end
        $display("No errors");
        $finish;
    end

    initial begin : watchdog
        #((CYCLES + 100) * PERIOD);
        $display("Timeout: the stimulus did not finish in the expected time");
        stop_run();
    end

endmodule
